//--- logic/axist_link_pkg.sv
// ----------------------------------------
// Shared widths, channel word layout and enums for the simplex link
// Word bits 67..79 are unused and always zero
// STB_INTV must be a multiple of the word rate
// ----------------------------------------

package axist_link_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int unsigned DATA_W            = 64;        // Stream beat
	localparam int unsigned PHY_W             = 80;        // Channel word

	// ----------------------------------------
	// Channel word layout
	// ----------------------------------------
	localparam int unsigned PUSH_BIT          = 0;         // Word carries data
	localparam int unsigned STB_BIT           = 1;         // Alignment strobe
	localparam int unsigned MARKER_BIT        = 39;        // Rate marker
	localparam int unsigned DATA_LO_POS       = 2;         // Data bits 36..0
	localparam int unsigned DATA_LO_W         = 37;
	localparam int unsigned DATA_HI_POS       = 40;        // Data bits 63..37
	localparam int unsigned DATA_HI_W         = 27;

	// ----------------------------------------
	// Link defaults
	// ----------------------------------------
	localparam int unsigned STB_INTV_DEF      = 24;        // Words between strobes
	localparam int unsigned RX_FIFO_DEPTH_DEF = 8;
	// Pack holding reg, framer word reg, follower input reg
	localparam int unsigned IN_FLIGHT         = 3;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PHY_W-1:0]  phy_word_t;

	// Value is the marker period in words
	typedef enum logic [2:0]
	{
		FULL    = 3'd1,
		HALF    = 3'd2,
		QUARTER = 3'd4
	} rate_e;

	typedef enum logic [1:0]
	{
		ALIGN_SEEK,                                            // Wait for any strobe
		ALIGN_VERIFY,                                          // Check second strobe spacing
		ALIGN_LOCKED
	} align_state_e;

endpackage

//--- logic/phy_lane_if.sv
// ----------------------------------------
// Framed channel word, one new word per clock
// No handshake, the sink must take every word
// ----------------------------------------

`timescale 1ns/1ps

interface phy_lane_if;

	axist_link_pkg::data_t word_data;                          // Zero unless push
	logic                  push;
	logic                  marker;
	logic                  strobe;

	// Packs the fields into the 80-bit word per the package layout
	function automatic axist_link_pkg::phy_word_t flatten();
		axist_link_pkg::phy_word_t w;
		w = '0;
		w[axist_link_pkg::PUSH_BIT]   = push;
		w[axist_link_pkg::STB_BIT]    = strobe;
		w[axist_link_pkg::MARKER_BIT] = marker;
		w[axist_link_pkg::DATA_LO_POS +: axist_link_pkg::DATA_LO_W] =
			word_data[axist_link_pkg::DATA_LO_W-1:0];
		w[axist_link_pkg::DATA_HI_POS +: axist_link_pkg::DATA_HI_W] =
			word_data[axist_link_pkg::DATA_W-1:axist_link_pkg::DATA_LO_W];
		return w;
	endfunction

	modport src (output word_data, output push, output marker, output strobe);
	modport dst (input word_data, input push, input marker, input strobe, import flatten);

endinterface

//--- logic/leader_tx_pack.sv
// ----------------------------------------
// Leader stream input, one beat held at a time
// Ready needs both enables, remote alignment and FIFO room
// A held beat waits while the link is offline
// ----------------------------------------

`timescale 1ns/1ps

module leader_tx_pack
(
	input  logic                  m_wr_clk,
	input  logic                  m_wr_rst_n,
	input  axist_link_pkg::data_t i_tdata,
	input  logic                  i_tvalid,
	input  logic                  i_sl_tx_transfer_en,
	input  logic                  i_ms_tx_transfer_en,
	input  logic                  i_align_done,
	input  logic                  i_fifo_near_full,
	output logic                  o_tready,
	output axist_link_pkg::data_t o_data,
	output logic                  o_push
);

	logic                  online;
	logic                  accept;
	logic                  hold_vld;
	axist_link_pkg::data_t hold_data;

	assign online   = i_sl_tx_transfer_en & i_ms_tx_transfer_en;
	// When online the held beat leaves this cycle, so no hold check
	assign o_tready = online & i_align_done & ~i_fifo_near_full;
	assign accept   = i_tvalid & o_tready;                       // Stream handshake

	// ----------------------------------------
	// Holding register
	// ----------------------------------------
	always_ff @(posedge m_wr_clk)
	begin
		if (!m_wr_rst_n)
			hold_vld <= 1'b0;
		else if (accept)
			hold_vld <= 1'b1;                                    // Refill, even while draining
		else if (online)
			hold_vld <= 1'b0;                                    // Beat handed to framer
	end

	always_ff @(posedge m_wr_clk)
	begin
		if (accept)
			hold_data <= i_tdata;
	end

	// One push per accepted beat, only while the framer runs
	assign o_push = hold_vld & online;
	assign o_data = hold_data;

endmodule

//--- logic/channel_framer.sv
// ----------------------------------------
// Builds one channel word per clock
// Marker every LOCAL_RATE words, strobe every STB_INTV words
// Counters and pushes stop while offline, words go to zero
// ----------------------------------------

`timescale 1ns/1ps

module channel_framer
#(
	parameter axist_link_pkg::rate_e LOCAL_RATE = axist_link_pkg::HALF,
	parameter int unsigned           STB_INTV   = axist_link_pkg::STB_INTV_DEF
)
(
	input  logic                  m_wr_clk,
	input  logic                  m_wr_rst_n,
	input  logic                  i_online,
	input  axist_link_pkg::data_t i_data,
	input  logic                  i_push,
	phy_lane_if.src               o_lane
);

	localparam int unsigned RATE_N = int'(LOCAL_RATE);
	localparam int unsigned MRK_W  = (RATE_N > 1) ? $clog2(RATE_N) : 1;
	localparam int unsigned STB_W  = $clog2(STB_INTV);

	logic [MRK_W-1:0]      mrk_cnt;
	logic [STB_W-1:0]      stb_cnt;
	logic                  mrk_hit;
	logic                  stb_hit;
	logic                  push_q;
	logic                  mrk_q;
	logic                  stb_q;
	axist_link_pkg::data_t data_q;

	assign mrk_hit = (mrk_cnt == MRK_W'(RATE_N - 1));
	assign stb_hit = (stb_cnt == STB_W'(STB_INTV - 1));       // Always lands on a marker

	// ----------------------------------------
	// Marker and strobe counters
	// ----------------------------------------
	always_ff @(posedge m_wr_clk)
	begin
		if (!m_wr_rst_n)
		begin
			mrk_cnt <= '0;
			stb_cnt <= '0;
		end
		else if (i_online)
		begin
			mrk_cnt <= mrk_hit ? '0 : mrk_cnt + 1'b1;
			stb_cnt <= stb_hit ? '0 : stb_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// Word register
	// ----------------------------------------
	always_ff @(posedge m_wr_clk)
	begin
		if (!m_wr_rst_n)
		begin
			push_q <= 1'b0;
			mrk_q  <= 1'b0;
			stb_q  <= 1'b0;
			data_q <= '0;                                        // Channel idles at zero
		end
		else
		begin
			push_q <= i_online & i_push;
			mrk_q  <= i_online & mrk_hit;
			stb_q  <= i_online & stb_hit;
			data_q <= (i_online & i_push) ? i_data : '0;
		end
	end

	assign o_lane.word_data = data_q;
	assign o_lane.push      = push_q;
	assign o_lane.marker    = mrk_q;
	assign o_lane.strobe    = stb_q;

endmodule

//--- logic/follower_rx_align.sv
// ----------------------------------------
// Follower word check, unpack and receive FIFO
// Every clock counts as one word for strobe spacing
// Held in reset while i_usermode_en is low
// RX_FIFO_DEPTH must be a power of two
// ----------------------------------------

`timescale 1ns/1ps

module follower_rx_align
#(
	parameter int unsigned STB_INTV      = axist_link_pkg::STB_INTV_DEF,
	parameter int unsigned RX_FIFO_DEPTH = axist_link_pkg::RX_FIFO_DEPTH_DEF
)
(
	input  logic                      m_wr_clk,
	input  logic                      m_wr_rst_n,
	input  logic                      i_usermode_en,
	input  axist_link_pkg::phy_word_t i_phy_word,
	input  logic                      i_rx_tready,
	output axist_link_pkg::data_t     o_rx_tdata,
	output logic                      o_rx_tvalid,
	output logic                      o_align_done,
	output logic                      o_align_err,
	output logic                      o_fifo_near_full
);

	localparam int unsigned AW       = $clog2(RX_FIFO_DEPTH);
	localparam int unsigned CNT_W    = AW + 1;
	localparam int unsigned WC_W     = $clog2(STB_INTV);
	localparam int unsigned NF_LEVEL = RX_FIFO_DEPTH - axist_link_pkg::IN_FLIGHT;

	logic                         rst_n;
	axist_link_pkg::phy_word_t    phy_q;
	logic                         q_push;
	logic                         q_stb;
	logic                         q_mrk;
	logic                         stb_due;
	logic                         stb_good;
	axist_link_pkg::align_state_e state;
	logic [WC_W-1:0]              wcnt;
	logic                         align_err_q;
	axist_link_pkg::data_t        mem [RX_FIFO_DEPTH];
	axist_link_pkg::data_t        wr_data;
	logic [AW-1:0]                wr_ptr;
	logic [AW-1:0]                rd_ptr;
	logic [CNT_W-1:0]             count;
	logic                         wr_en;
	logic                         rd_en;

	assign rst_n = m_wr_rst_n & i_usermode_en;

	always_ff @(posedge m_wr_clk)
	begin
		if (!rst_n)
			phy_q <= '0;
		else
			phy_q <= i_phy_word;                                 // Input register
	end

	assign q_push   = phy_q[axist_link_pkg::PUSH_BIT];
	assign q_stb    = phy_q[axist_link_pkg::STB_BIT];
	assign q_mrk    = phy_q[axist_link_pkg::MARKER_BIT];
	assign stb_due  = (wcnt == WC_W'(STB_INTV - 1));           // STB_INTV words after last
	assign stb_good = q_stb & q_mrk;

	// ----------------------------------------
	// Strobe alignment
	// ----------------------------------------
	always_ff @(posedge m_wr_clk)
	begin
		if (!rst_n)
		begin
			state       <= axist_link_pkg::ALIGN_SEEK;
			wcnt        <= '0;
			align_err_q <= 1'b0;
		end
		else
		begin
			// Restart the spacing count on any strobe or when one was due
			wcnt <= (q_stb || stb_due) ? '0 : wcnt + 1'b1;
			case (state)
				axist_link_pkg::ALIGN_SEEK:
				begin
					if (q_stb)
						state <= axist_link_pkg::ALIGN_VERIFY;
				end
				axist_link_pkg::ALIGN_VERIFY:
				begin
					if (stb_due)
						state <= stb_good ? axist_link_pkg::ALIGN_LOCKED
						                  : axist_link_pkg::ALIGN_SEEK;
					else if (q_stb)
						state <= axist_link_pkg::ALIGN_SEEK;     // Early strobe, start over
				end
				axist_link_pkg::ALIGN_LOCKED:
				begin
					if ((stb_due && !stb_good) || (!stb_due && q_stb))
						align_err_q <= 1'b1;                     // Sticky until reset
				end
				default:
					state <= axist_link_pkg::ALIGN_SEEK;
			endcase
		end
	end

	// ----------------------------------------
	// Receive FIFO
	// ----------------------------------------
	assign wr_en   = (state == axist_link_pkg::ALIGN_LOCKED) & q_push;
	assign rd_en   = o_rx_tvalid & i_rx_tready;
	assign wr_data = {phy_q[axist_link_pkg::DATA_HI_POS +: axist_link_pkg::DATA_HI_W],
	                  phy_q[axist_link_pkg::DATA_LO_POS +: axist_link_pkg::DATA_LO_W]};

	always_ff @(posedge m_wr_clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge m_wr_clk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;                         // Wraps, depth is 2**AW
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	assign o_rx_tvalid      = (count != '0);
	assign o_rx_tdata       = mem[rd_ptr];                     // Stable until read
	assign o_fifo_near_full = (count >= CNT_W'(NF_LEVEL));
	assign o_align_done     = (state == axist_link_pkg::ALIGN_LOCKED);
	assign o_align_err      = align_err_q;

endmodule

//--- logic/axist_simplex_link_top.sv
// ----------------------------------------
// Single-clock simplex leader to follower stream link
// o_phy_word must be looped back to i_phy_word outside
// A beat taken at edge N is on o_phy_word from edge N+1, sampled at N+2
// ----------------------------------------

`timescale 1ns/1ps

module axist_simplex_link_top
#(
	parameter axist_link_pkg::rate_e LOCAL_RATE    = axist_link_pkg::HALF,
	parameter int unsigned           STB_INTV      = axist_link_pkg::STB_INTV_DEF,
	parameter int unsigned           RX_FIFO_DEPTH = axist_link_pkg::RX_FIFO_DEPTH_DEF
)
(
	input  logic                      m_wr_clk,
	input  logic                      m_wr_rst_n,
	input  logic                      i_usermode_en,
	input  logic                      i_sl_tx_transfer_en,
	input  logic                      i_ms_tx_transfer_en,
	input  axist_link_pkg::data_t     i_tx_tdata,
	input  logic                      i_tx_tvalid,
	output logic                      o_tx_tready,
	output axist_link_pkg::phy_word_t o_phy_word,
	input  axist_link_pkg::phy_word_t i_phy_word,
	output axist_link_pkg::data_t     o_rx_tdata,
	output logic                      o_rx_tvalid,
	input  logic                      i_rx_tready,
	output logic                      o_align_done,
	output logic                      o_align_err
);

	logic                  framer_online;
	logic                  fifo_near_full;
	logic                  tx_push;
	axist_link_pkg::data_t tx_data;

	phy_lane_if lane ();

	assign framer_online = i_sl_tx_transfer_en & i_ms_tx_transfer_en;

	// ----------------------------------------
	// Leader side
	// ----------------------------------------
	leader_tx_pack u_tx_pack
	(
		.m_wr_clk            (m_wr_clk),
		.m_wr_rst_n          (m_wr_rst_n),
		.i_tdata             (i_tx_tdata),
		.i_tvalid            (i_tx_tvalid),
		.i_sl_tx_transfer_en (i_sl_tx_transfer_en),
		.i_ms_tx_transfer_en (i_ms_tx_transfer_en),
		.i_align_done        (o_align_done),                  // Remote side locked
		.i_fifo_near_full    (fifo_near_full),
		.o_tready            (o_tx_tready),
		.o_data              (tx_data),
		.o_push              (tx_push)
	);

	channel_framer #(.LOCAL_RATE(LOCAL_RATE), .STB_INTV(STB_INTV)) u_framer
	(
		.m_wr_clk   (m_wr_clk),
		.m_wr_rst_n (m_wr_rst_n),
		.i_online   (framer_online),
		.i_data     (tx_data),
		.i_push     (tx_push),
		.o_lane     (lane.src)
	);

	always_comb
	begin
		o_phy_word = lane.flatten();                          // Fields to bit positions
	end

	// ----------------------------------------
	// Follower side
	// ----------------------------------------
	follower_rx_align #(.STB_INTV(STB_INTV), .RX_FIFO_DEPTH(RX_FIFO_DEPTH)) u_rx_align
	(
		.m_wr_clk         (m_wr_clk),
		.m_wr_rst_n       (m_wr_rst_n),
		.i_usermode_en    (i_usermode_en),
		.i_phy_word       (i_phy_word),
		.i_rx_tready      (i_rx_tready),
		.o_rx_tdata       (o_rx_tdata),
		.o_rx_tvalid      (o_rx_tvalid),
		.o_align_done     (o_align_done),
		.o_align_err      (o_align_err),
		.o_fifo_near_full (fifo_near_full)
	);

endmodule

//--- test/tb_clk_gen.sv
// ----------------------------------------
// Testbench clock, 8 ns period
// Reset low for two rising edges, released on a falling edge
// ----------------------------------------

`timescale 1ns/1ps

module tb_clk_gen
(
	output logic o_clk,
	output logic o_rst_n
);

	initial
	begin
		o_clk = 1'b0;
		forever #4 o_clk = ~o_clk;
	end

	initial
	begin
		o_rst_n = 1'b0;
		repeat (2) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;                                          // Synchronous release
	end

endmodule

//--- test/tb_axist_simplex_link.sv
// ----------------------------------------
// Testbench for the simplex link with channel loopback
// Default parameters, HALF rate and 24 word strobe interval
// Follower reset is done through i_usermode_en
// ----------------------------------------

`timescale 1ns/1ps

module tb_axist_simplex_link;

	logic                      m_wr_clk;
	logic                      m_wr_rst_n;
	logic                      i_usermode_en;
	logic                      i_sl_tx_transfer_en;
	logic                      i_ms_tx_transfer_en;
	axist_link_pkg::data_t     i_tx_tdata;
	logic                      i_tx_tvalid;
	logic                      o_tx_tready;
	axist_link_pkg::phy_word_t o_phy_word;
	axist_link_pkg::phy_word_t i_phy_word;
	axist_link_pkg::data_t     o_rx_tdata;
	logic                      o_rx_tvalid;
	logic                      i_rx_tready;
	logic                      o_align_done;
	logic                      o_align_err;

	logic                      flip_stb;                     // Corrupts one looped word
	logic                      rx_random;
	axist_link_pkg::data_t     sent_q [$];                   // For the output stream
	axist_link_pkg::data_t     phy_exp_q [$];                // For push words
	int                        errors;
	int                        tests_run;
	int                        tests_failed;
	int                        rx_count;
	int                        cnt;
	int                        err_mark;

	tb_clk_gen u_clk (.o_clk(m_wr_clk), .o_rst_n(m_wr_rst_n));

	axist_simplex_link_top UUT
	(
		.m_wr_clk(m_wr_clk), .m_wr_rst_n(m_wr_rst_n), .i_usermode_en(i_usermode_en),
		.i_sl_tx_transfer_en(i_sl_tx_transfer_en), .i_ms_tx_transfer_en(i_ms_tx_transfer_en),
		.i_tx_tdata(i_tx_tdata), .i_tx_tvalid(i_tx_tvalid), .o_tx_tready(o_tx_tready),
		.o_phy_word(o_phy_word), .i_phy_word(i_phy_word), .o_rx_tdata(o_rx_tdata),
		.o_rx_tvalid(o_rx_tvalid), .i_rx_tready(i_rx_tready), .o_align_done(o_align_done),
		.o_align_err(o_align_err)
	);

	assign i_phy_word = flip_stb ? (o_phy_word ^ (80'd1 << axist_link_pkg::STB_BIT)) : o_phy_word;

	// ----------------------------------------
	// Reference functions
	// ----------------------------------------
	function automatic axist_link_pkg::phy_word_t expected_phy_data(axist_link_pkg::data_t d);
		axist_link_pkg::phy_word_t w;
		w = '0;
		w[38:2]  = d[36:0];                                      // Low field
		w[66:40] = d[63:37];                                     // High field
		return w;
	endfunction

	function automatic logic expected_marker(int idx);
		return (idx % 2) == 0;
	endfunction

	function automatic logic expected_strobe(int idx);
		return (idx % 24) == 0;
	endfunction

	task automatic report_test(input string name);
		tests_run++;
		if (errors != err_mark)
		begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_mark);
		end
		else
			$display("Test %s: ok", name);
		err_mark = errors;
	endtask

	// Sends n random beats with random gaps, each waiting for ready
	task automatic send_beats(input int n);
		int  gap;
		int  tries;
		bit  done;
		for (int i = 0; i < n; i++)
		begin
			gap = $urandom_range(0, 2);
			repeat (gap) @(negedge m_wr_clk);
			i_tx_tdata  = {$urandom, $urandom};
			i_tx_tvalid = 1'b1;
			done        = 1'b0;
			tries       = 0;
			while (!done && tries < 300)
			begin
				#1;
				if (o_tx_tready)
				begin
					sent_q.push_back(i_tx_tdata);
					phy_exp_q.push_back(i_tx_tdata);
					done = 1'b1;
				end
				@(negedge m_wr_clk);
				tries++;
			end
			i_tx_tvalid = 1'b0;
			if (!done)
			begin
				$display("Timeout at %0t: beat %0d was never accepted", $time, i);
				errors++;
				return;
			end
		end
	endtask

	task automatic wait_drained();
		int tries;
		tries = 0;
		while ((sent_q.size() != 0 || phy_exp_q.size() != 0) && tries < 2000)
		begin
			@(negedge m_wr_clk);
			tries++;
		end
		if (tries >= 2000)
		begin
			$display("Timeout at %0t: %0d beats never reached the output", $time, sent_q.size());
			errors++;
		end
	endtask

	task automatic wait_align();
		int tries;
		tries = 0;
		while (!o_align_done && tries < 200)
		begin
			@(negedge m_wr_clk);
			tries++;
		end
		if (!o_align_done)
		begin
			$display("Timeout at %0t: follower never aligned", $time);
			errors++;
		end
	endtask

	// ----------------------------------------
	// Output stream compare process
	// ----------------------------------------
	initial
	begin
		i_rx_tready = 1'b0;
		forever
		begin
			@(negedge m_wr_clk);
			i_rx_tready = rx_random ? (($urandom % 4) != 0) : 1'b1;
			#1;
			if (o_rx_tvalid && i_rx_tready)
			begin
				rx_count++;
				assert (sent_q.size() != 0)
				else
				begin
					$display("Output beat at %0t with no beat sent", $time);
					errors++;
				end
				if (sent_q.size() != 0)
				begin
					assert (o_rx_tdata == sent_q[0])
					else
					begin
						$display("[ERROR] %0t o_rx_tdata got %h expected %h",
							$time, o_rx_tdata, sent_q[0]);
						errors++;
					end
					void'(sent_q.pop_front());
				end
			end
		end
	end

	// Channel word and gating monitor
	initial
	begin
		axist_link_pkg::phy_word_t exp;
		axist_link_pkg::phy_word_t got;
		forever
		begin
			@(negedge m_wr_clk);
			#1;
			assert (!o_tx_tready || o_align_done)
			else
			begin
				$display("[ERROR] %0t o_tx_tready got 1 expected 0 before alignment", $time);
				errors++;
			end
			if (o_phy_word[axist_link_pkg::PUSH_BIT])
			begin
				assert (phy_exp_q.size() != 0)
				else
				begin
					$display("Push word at %0t with no beat accepted", $time);
					errors++;
				end
				if (phy_exp_q.size() != 0)
				begin
					exp     = expected_phy_data(phy_exp_q.pop_front());
					exp[0]  = 1'b1;
					got     = o_phy_word;
					got[1]  = 1'b0;                              // Framing bits are don't care here
					got[39] = 1'b0;
					assert (got == exp)
					else
					begin
						$display("[ERROR] %0t o_phy_word got %h expected %h",
							$time, got, exp);
						errors++;
					end
				end
			end
		end
	end

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		void'($urandom(32'hdb2c_cf4c));
		i_usermode_en       = 1'b1;
		i_sl_tx_transfer_en = 1'b0;
		i_ms_tx_transfer_en = 1'b0;
		i_tx_tdata          = '0;
		i_tx_tvalid         = 1'b0;
		flip_stb            = 1'b0;
		rx_random           = 1'b0;
		errors              = 0;
		tests_run           = 0;
		tests_failed        = 0;
		rx_count            = 0;
		err_mark            = 0;

		// 1. Reset state, checked during and one cycle after reset
		for (int i = 0; i < 4; i++)
		begin
			@(negedge m_wr_clk);
			#1;
			assert (!o_tx_tready && !o_rx_tvalid && !o_align_done && !o_align_err
				&& o_phy_word == '0)
			else
			begin
				$display("[ERROR] %0t o_tx_tready,o_rx_tvalid,o_align_done,o_align_err got %b%b%b%b",
					$time, o_tx_tready, o_rx_tvalid, o_align_done, o_align_err);
				$display("[ERROR] %0t o_phy_word got %h expected 0, flags expected 0000",
					$time, o_phy_word);
				errors++;
			end
		end
		report_test("reset state");

		// 2. Framing, indexed from the first strobe
		@(negedge m_wr_clk);
		i_sl_tx_transfer_en = 1'b1;
		i_ms_tx_transfer_en = 1'b1;
		cnt = 0;
		while (!o_phy_word[axist_link_pkg::STB_BIT] && cnt < 60)
		begin
			@(negedge m_wr_clk);
			cnt++;
		end
		if (cnt >= 60)
		begin
			$display("Timeout at %0t: no strobe word seen", $time);
			errors++;
		end
		for (int k = 0; k < 48; k++)
		begin
			assert (o_phy_word[39] == expected_marker(k) && o_phy_word[1] == expected_strobe(k))
			else
			begin
				$display("[ERROR] %0t marker,strobe got %b%b expected %b%b", $time,
					o_phy_word[39], o_phy_word[1], expected_marker(k), expected_strobe(k));
				errors++;
			end
			@(negedge m_wr_clk);
		end
		report_test("framing");

		// 3. Alignment
		wait_align();
		assert (!o_align_err)
		else
		begin
			$display("[ERROR] %0t o_align_err got 1 expected 0", $time);
			errors++;
		end
		report_test("alignment");

		// 4. Random data with back-pressure
		rx_random = 1'b1;
		send_beats(200);
		wait_drained();
		report_test("data transfer");

		// 5. One transfer enable low, the follower loses strobes meanwhile
		@(negedge m_wr_clk);
		i_ms_tx_transfer_en = 1'b0;
		i_tx_tvalid         = 1'b1;
		for (int i = 0; i < 30; i++)
		begin
			@(negedge m_wr_clk);
			#1;
			assert (!o_tx_tready && !o_phy_word[axist_link_pkg::PUSH_BIT])
			else
			begin
				$display("[ERROR] %0t o_tx_tready,push got %b%b expected 00", $time,
					o_tx_tready, o_phy_word[0]);
				errors++;
			end
		end
		i_tx_tvalid         = 1'b0;
		i_ms_tx_transfer_en = 1'b1;
		send_beats(20);
		wait_drained();
		report_test("transfer enable");

		// 6. Strobe corruption after a fresh lock
		@(negedge m_wr_clk);
		i_usermode_en = 1'b0;
		repeat (2) @(negedge m_wr_clk);
		i_usermode_en = 1'b1;
		wait_align();
		repeat (5) @(negedge m_wr_clk);
		assert (!o_align_err)
		else
		begin
			$display("[ERROR] %0t o_align_err got 1 expected 0", $time);
			errors++;
		end
		flip_stb = 1'b1;
		@(negedge m_wr_clk);
		flip_stb = 1'b0;
		cnt = 0;
		while (!o_align_err && cnt < 60)
		begin
			@(negedge m_wr_clk);
			cnt++;
		end
		if (!o_align_err)
		begin
			$display("Timeout at %0t: corrupted strobe raised no alignment error", $time);
			errors++;
		end
		for (int i = 0; i < 50; i++)
		begin
			@(negedge m_wr_clk);
			assert (o_align_err)
			else
			begin
				$display("[ERROR] %0t o_align_err got 0 expected 1", $time);
				errors++;
			end
		end
		i_usermode_en = 1'b0;
		repeat (2) @(negedge m_wr_clk);
		#1;
		assert (!o_align_err)
		else
		begin
			$display("[ERROR] %0t o_align_err got 1 expected 0 after reset", $time);
			errors++;
		end
		report_test("strobe corruption");

		$display("Tests run %0d, failed %0d, errors %0d, beats received %0d",
			tests_run, tests_failed, errors, rx_count);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

//--- axist_simplex_link.f
logic/axist_link_pkg.sv
logic/phy_lane_if.sv
logic/leader_tx_pack.sv
logic/channel_framer.sv
logic/follower_rx_align.sv
logic/axist_simplex_link_top.sv
test/tb_clk_gen.sv
test/tb_axist_simplex_link.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the simplex link testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_axist_simplex_link \
	-f axist_simplex_link.f

./obj_dir/Vtb_axist_simplex_link > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
exit 0
